// File: bench/issue_sva.sv
`timescale 1ns/10ps
`default_nettype none

module issue_sva
    import issue_pkg::*;
(
    input wire logic                clk,
    input wire logic                rstn,
    input wire logic                i_flush,
    input wire logic                i_stall,
    input wire logic [1:0]          i_issue_num,
    input wire logic [1:0]          i_head_valid,
    input wire logic [IB_CNT_W-1:0] i_occ
);

    ////////////////////////////////////////////////////////////////////////////
    // buffer and selector invariants
    ////////////////////////////////////////////////////////////////////////////

    a_occ_bound: assert property (@(posedge clk) disable iff (!rstn)
        i_occ <= IB_CNT_W'(IB_DEPTH))
        else $error("buffer occupancy above its depth");

    // never release more than the head holds
    a_issue_le_valid: assert property (@(posedge clk) disable iff (!rstn)
        i_issue_num <= (2'(i_head_valid[1]) + 2'(i_head_valid[0])))
        else $error("issue count above the valid head entries");

    a_flush_empties: assert property (@(posedge clk) disable iff (!rstn)
        i_flush |=> (i_head_valid == 2'b00))
        else $error("head still valid the cycle after a flush");

    a_stall_holds: assert property (@(posedge clk) disable iff (!rstn)
        i_stall |-> (i_issue_num == 2'd0))
        else $error("issue during stall");

endmodule

// occupancy lives inside the buffer, stall and issue count at the top
bind issue_top issue_sva u_issue_sva (
    .clk          (clk),
    .rstn         (rstn),
    .i_flush      (i_flush),
    .i_stall      (i_stall),
    .i_issue_num  (issue_num),
    .i_head_valid (head_valid),
    .i_occ        (u_issue_buffer.occ)
);

`default_nettype wire

// File: bench/issue_tb.sv
`timescale 1ns/10ps
`default_nettype none

module issue_tb
    import issue_pkg::*;
();

    typedef struct packed {
        logic [3:0]  test;
        logic        va;
        logic        vb;
        logic [31:0] ia;
        logic [31:0] ib;
        logic [31:0] pca;          // slot b sits at pca + 4
        logic        flush;
        logic        stall;
        logic [1:0]  exp_mask;     // o_issue_valid while this row is driven
    } row_t;

    // one queued instruction as the reference model sees it
    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  src1;
        logic [4:0]  src2;
        logic [4:0]  dst;
        logic        wr;
        logic        mem;
        logic        ill;
    } entry_t;

    logic        clk;
    logic        rstn;
    logic        valid_a, valid_b, flush, stall;
    logic [31:0] inst_a, inst_b, pc_a, pc_b;
    logic [1:0]  issue_valid;
    logic [4:0]  raddr_a1, raddr_a2, raddr_b1, raddr_b2;
    logic [31:0] pc_out_a, pc_out_b;
    logic        illegal_a;
    logic        full;

    row_t        rows [$];
    entry_t      model_q [$];
    logic [31:0] pc_gen;
    logic        exp_full;
    int          n_err;
    int          n_chk;
    int          test_err_base;
    string       test_names [1:6] = '{"in-order delivery", "pair hazard", "decode fields",
                                      "stall", "flush", "almost-full"};

    issue_top u_issue_top (
        .clk           (clk),
        .rstn          (rstn),
        .i_valid_a     (valid_a),
        .i_valid_b     (valid_b),
        .i_inst_a      (inst_a),
        .i_inst_b      (inst_b),
        .i_pc_a        (pc_a),
        .i_pc_b        (pc_b),
        .i_flush       (flush),
        .i_stall       (stall),
        .o_issue_valid (issue_valid),
        .o_raddr_a1    (raddr_a1),
        .o_raddr_a2    (raddr_a2),
        .o_raddr_b1    (raddr_b1),
        .o_raddr_b2    (raddr_b2),
        .o_pc_a        (pc_out_a),
        .o_pc_b        (pc_out_b),
        .o_illegal_a   (illegal_a),
        .o_full        (full)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // instruction words and their expected decode
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [4:0] any_hi_reg();
        return {1'b1, 4'($urandom)};   // r16..r31, apart from the small destinations
    endfunction

    function automatic logic [4:0] small_dst();
        return 5'(1 + $urandom % 7);
    endfunction

    function automatic logic [31:0] enc_alu_r(input logic [4:0] rd, input logic [4:0] rj,
                                              input logic [4:0] rk);
        return {OP_ALU_R, 11'($urandom), rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_imm(input logic [5:0] op, input logic [4:0] rd,
                                            input logic [4:0] rj);
        return {op, 16'($urandom), rj, rd};
    endfunction

    function automatic entry_t decode_word(input logic [31:0] w, input logic [31:0] pc);
        entry_t     e;
        logic [5:0] op;
        op     = w[31:26];
        e      = '0;
        e.pc   = pc;
        e.src1 = w[9:5];               // rj in every legal form
        e.dst  = w[4:0];
        e.wr   = (op == OP_ALU_R) || (op == OP_ALU_I) || (op == OP_LOAD);
        e.mem  = (op == OP_LOAD) || (op == OP_STORE);
        e.ill  = !(e.wr || e.mem || (op == OP_BRANCH));
        if (op == OP_ALU_R)
            e.src2 = w[14:10];
        else if ((op == OP_STORE) || (op == OP_BRANCH))
            e.src2 = w[4:0];           // rd is read, not written
        return e;
    endfunction

    task automatic add_row(input logic [3:0] t, input logic va, input logic vb,
                           input logic [31:0] ia, input logic [31:0] ib,
                           input logic fl, input logic st, input logic [1:0] em);
        rows.push_back('{t, va, vb, ia, ib, pc_gen, fl, st, em});
        pc_gen = pc_gen + 32'd8;
    endtask

    task automatic add_indep(input logic [3:0] t, input logic fl, input logic st,
                             input logic [1:0] em);
        add_row(t, 1'b1, 1'b1, enc_alu_r(small_dst(), any_hi_reg(), any_hi_reg()),
                enc_imm(OP_ALU_I, small_dst(), any_hi_reg()), fl, st, em);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checking and the reference queue
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        n_chk++;
        if (got !== exp) begin
            n_err++;
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic drive_row(input row_t r);
        valid_a = r.va;
        valid_b = r.vb;
        inst_a  = r.ia;
        inst_b  = r.ib;
        pc_a    = r.pca;
        pc_b    = r.pca + 32'd4;
        flush   = r.flush;
        stall   = r.stall;
    endtask

    task automatic check_cycle(input logic st, output logic [1:0] mask);
        entry_t a;
        entry_t b;
        logic   take_a;
        logic   take_b;
        a = '0;
        b = '0;
        if (model_q.size() > 0)
            a = model_q[0];
        if (model_q.size() > 1)
            b = model_q[1];
        take_a = (model_q.size() > 0) && !st;
        take_b = take_a && (model_q.size() > 1);
        if (a.wr && (a.dst != 5'd0) && ((b.src1 == a.dst) || (b.src2 == a.dst)))
            take_b = 1'b0;             // b needs a's result
        if (a.mem && b.mem)
            take_b = 1'b0;
        mask = {take_a, take_b};
        check_val("o_issue_valid", 32'(issue_valid), 32'(mask));
        check_val("o_illegal_a", 32'(illegal_a), 32'(a.ill));
        check_val("o_full", 32'(full), 32'(exp_full));
        if (take_a) begin
            check_val("o_pc_a", pc_out_a, a.pc);
            if (!a.ill) begin      // read ports of an illegal word are undefined
                check_val("o_raddr_a1", 32'(raddr_a1), 32'(a.src1));
                check_val("o_raddr_a2", 32'(raddr_a2), 32'(a.src2));
            end
        end
        if (take_b) begin
            check_val("o_pc_b", pc_out_b, b.pc);
            if (!b.ill) begin
                check_val("o_raddr_b1", 32'(raddr_b1), 32'(b.src1));
                check_val("o_raddr_b2", 32'(raddr_b2), 32'(b.src2));
            end
        end
    endtask

    task automatic model_update(input row_t r, input logic [1:0] mask);
        if (mask[1])
            model_q.delete(0);
        if (mask[0])
            model_q.delete(0);
        if (r.flush) begin
            model_q.delete();          // same-cycle writes are dropped too
        end else if (r.va) begin
            model_q.push_back(decode_word(r.ia, r.pca));
            if (r.vb)
                model_q.push_back(decode_word(r.ib, r.pca + 32'd4));
        end
        exp_full = (model_q.size() >= int'(IB_FULL_LEVEL));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int         drain_cycles;
        logic [1:0] mask;
        void'($urandom(32'he65fa3be));
        rstn     = 1'b0;
        drive_row('0);
        pc_gen   = 32'h0000_1000;
        exp_full = 1'b0;
        n_err    = 0;
        n_chk    = 0;
        test_err_base = 0;

        add_indep(1, 0, 0, 2'b00);
        add_row(1, 1, 1, enc_imm(OP_LOAD, 5'd3, any_hi_reg()),
                enc_alu_r(5'd4, any_hi_reg(), any_hi_reg()), 0, 0, 2'b11);
        add_row(1, 1, 1, enc_alu_r(5'd5, any_hi_reg(), any_hi_reg()),
                enc_imm(OP_STORE, any_hi_reg(), any_hi_reg()), 0, 0, 2'b11);
        add_row(1, 0, 0, '0, '0, 0, 0, 2'b11);
        add_row(1, 0, 0, '0, '0, 0, 0, 2'b00);
        // raw on r3, then a load/store pair, then r0 and store data hazards
        add_row(2, 1, 1, enc_alu_r(5'd3, any_hi_reg(), any_hi_reg()),
                enc_alu_r(any_hi_reg(), 5'd3, any_hi_reg()), 0, 0, 2'b00);
        add_row(2, 0, 0, '0, '0, 0, 0, 2'b10);
        add_row(2, 0, 0, '0, '0, 0, 0, 2'b10);
        add_row(2, 1, 1, enc_imm(OP_LOAD, 5'd4, any_hi_reg()),
                enc_imm(OP_STORE, any_hi_reg(), any_hi_reg()), 0, 0, 2'b00);
        add_indep(2, 0, 0, 2'b10);
        add_row(2, 0, 0, '0, '0, 0, 0, 2'b11);
        add_row(2, 0, 0, '0, '0, 0, 0, 2'b10);
        add_row(2, 1, 1, enc_alu_r(5'd0, any_hi_reg(), any_hi_reg()),
                enc_alu_r(any_hi_reg(), 5'd0, 5'd0), 0, 0, 2'b00);
        add_row(2, 1, 1, enc_imm(OP_ALU_I, 5'd6, any_hi_reg()),
                enc_imm(OP_STORE, 5'd6, any_hi_reg()), 0, 0, 2'b11);
        add_row(2, 0, 0, '0, '0, 0, 0, 2'b10);
        add_row(2, 0, 0, '0, '0, 0, 0, 2'b10);
        add_row(3, 1, 1, enc_imm(OP_BRANCH, any_hi_reg(), any_hi_reg()),
                enc_imm(OP_STORE, any_hi_reg(), any_hi_reg()), 0, 0, 2'b00);
        add_row(3, 1, 1, {6'h3f, 26'($urandom)}, enc_imm(OP_LOAD, 5'd7, any_hi_reg()),
                0, 0, 2'b11);
        add_row(3, 0, 0, '0, '0, 0, 0, 2'b11);
        add_row(3, 0, 0, '0, '0, 0, 0, 2'b00);
        add_indep(4, 0, 1, 2'b00);
        add_indep(4, 0, 1, 2'b00);
        add_row(4, 0, 0, '0, '0, 0, 1, 2'b00);
        add_row(4, 0, 0, '0, '0, 0, 0, 2'b11);
        add_row(4, 0, 0, '0, '0, 0, 0, 2'b11);
        add_row(4, 0, 0, '0, '0, 0, 0, 2'b00);
        add_indep(5, 0, 0, 2'b00);
        add_indep(5, 0, 1, 2'b00);
        add_indep(5, 1, 1, 2'b00);     // flush with a write in the same cycle
        add_row(5, 0, 0, '0, '0, 0, 0, 2'b00);
        add_indep(5, 0, 0, 2'b00);
        add_row(5, 0, 0, '0, '0, 0, 0, 2'b11);
        add_row(5, 0, 0, '0, '0, 0, 0, 2'b00);
        repeat (5) add_indep(6, 0, 1, 2'b00);   // fill to ten under stall
        add_row(6, 0, 0, '0, '0, 0, 1, 2'b00);
        repeat (5) add_row(6, 0, 0, '0, '0, 0, 0, 2'b11);
        add_row(6, 0, 0, '0, '0, 0, 0, 2'b00);

        for (int c = 0; c < 4; c++)
            @(posedge clk);
        #1 rstn = 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            #1 drive_row(rows[i]);
            #1 check_cycle(rows[i].stall, mask);
            check_val("o_issue_valid (table)", 32'(issue_valid), 32'(rows[i].exp_mask));
            model_update(rows[i], mask);
            if ((i == rows.size() - 1) || (rows[i + 1].test != rows[i].test)) begin
                $display("test %0d %s: %0d errors", rows[i].test, test_names[rows[i].test],
                         n_err - test_err_base);
                test_err_base = n_err;
            end
        end

        // let anything still queued drain out
        drain_cycles = 0;
        while ((model_q.size() != 0) && (drain_cycles < 40)) begin
            @(posedge clk);
            #1 drive_row('0);
            #1 check_cycle(1'b0, mask);
            model_update('0, mask);
            drain_cycles++;
        end
        if (model_q.size() != 0)
            $display("timeout: buffer did not drain, %0d entries left", model_q.size());

        $display("checks %0d, errors %0d", n_chk, n_err);
        if ((n_err == 0) && (model_q.size() == 0)) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
logic/issue_pkg.sv
logic/slot_if.sv
logic/inst_decoder.sv
logic/issue_buffer.sv
logic/issue_select.sv
logic/issue_top.sv
bench/issue_sva.sv
bench/issue_tb.sv

// File: logic/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decoder
    import issue_pkg::*;
(
    input  wire logic [31:0] i_inst,
    input  wire logic [31:0] i_pc,
    input  wire logic        i_valid,
    slot_if.producer         o_slot
);

    inst_word_u  word;
    logic [31:0] imm_sext;

    assign word     = i_inst;
    assign imm_sext = {{16{word.i.imm16[15]}}, word.i.imm16};

    assign o_slot.valid = i_valid;
    assign o_slot.pc    = i_pc;

    ////////////////////////////////////////////////////////////////////////////
    // field select by opcode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // unused read ports stay at r0 so pair hazard compares stay simple
        o_slot.src1       = 5'd0;
        o_slot.src2       = 5'd0;
        o_slot.dst        = 5'd0;
        o_slot.writes_dst = 1'b0;
        o_slot.is_mem     = 1'b0;
        o_slot.imm        = 32'd0;
        o_slot.illegal    = 1'b0;

        case (word.r.opcode)
            OP_ALU_R: begin
                o_slot.src1       = word.r.rj;
                o_slot.src2       = word.r.rk;
                o_slot.dst        = word.r.rd;
                o_slot.writes_dst = 1'b1;
            end
            OP_ALU_I: begin
                o_slot.src1       = word.i.rj;
                o_slot.dst        = word.i.rd;
                o_slot.writes_dst = 1'b1;
                o_slot.imm        = imm_sext;
            end
            OP_LOAD: begin
                o_slot.src1       = word.i.rj;   // base
                o_slot.dst        = word.i.rd;
                o_slot.writes_dst = 1'b1;
                o_slot.is_mem     = 1'b1;
                o_slot.imm        = imm_sext;    // offset
            end
            OP_STORE: begin
                o_slot.src1   = word.i.rj;       // base
                o_slot.src2   = word.i.rd;       // store data
                o_slot.is_mem = 1'b1;
                o_slot.imm    = imm_sext;
            end
            OP_BRANCH: begin
                o_slot.src1 = word.i.rj;
                o_slot.src2 = word.i.rd;         // compared against rj
                o_slot.imm  = imm_sext;          // branch offset
            end
            default: begin
                o_slot.illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/issue_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module issue_buffer
    import issue_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rstn,

    slot_if.consumer        i_in_a,
    slot_if.consumer        i_in_b,

    input  wire logic       i_flush,
    input  wire logic [1:0] i_issue_num,

    slot_if.producer        o_head_a,
    slot_if.producer        o_head_b,
    output      logic [1:0] o_head_valid,
    output      logic       o_full
);

    ////////////////////////////////////////////////////////////////////////////
    // entry storage, one array per slot field
    ////////////////////////////////////////////////////////////////////////////

    logic [31:0] pc_q      [IB_DEPTH];
    logic [4:0]  src1_q    [IB_DEPTH];
    logic [4:0]  src2_q    [IB_DEPTH];
    logic [4:0]  dst_q     [IB_DEPTH];
    logic        wr_dst_q  [IB_DEPTH];
    logic        is_mem_q  [IB_DEPTH];
    logic [31:0] imm_q     [IB_DEPTH];
    logic        illegal_q [IB_DEPTH];

    logic [IB_PTR_W-1:0] head_ptr;      // next free entry
    logic [IB_PTR_W-1:0] tail_ptr;      // oldest entry
    logic [IB_PTR_W-1:0] head_ptr_p1;
    logic [IB_PTR_W-1:0] tail_ptr_p1;
    logic [IB_CNT_W-1:0] occ;
    logic [IB_CNT_W-1:0] occ_next;
    logic [1:0]          num_wr;
    logic [1:0]          head_valid_d;

    // slot b only goes in behind a valid slot a
    assign num_wr = i_in_a.valid ? (i_in_b.valid ? 2'd2 : 2'd1) : 2'd0;

    assign head_ptr_p1 = head_ptr + 1'b1;   // wraps at IB_DEPTH
    assign tail_ptr_p1 = tail_ptr + 1'b1;

    assign occ_next = occ - IB_CNT_W'(i_issue_num) + IB_CNT_W'(num_wr);

    always_ff @(posedge clk) begin
        if (i_in_a.valid) begin
            pc_q[head_ptr]      <= i_in_a.pc;
            src1_q[head_ptr]    <= i_in_a.src1;
            src2_q[head_ptr]    <= i_in_a.src2;
            dst_q[head_ptr]     <= i_in_a.dst;
            wr_dst_q[head_ptr]  <= i_in_a.writes_dst;
            is_mem_q[head_ptr]  <= i_in_a.is_mem;
            imm_q[head_ptr]     <= i_in_a.imm;
            illegal_q[head_ptr] <= i_in_a.illegal;
        end
        if (i_in_a.valid && i_in_b.valid) begin
            pc_q[head_ptr_p1]      <= i_in_b.pc;
            src1_q[head_ptr_p1]    <= i_in_b.src1;
            src2_q[head_ptr_p1]    <= i_in_b.src2;
            dst_q[head_ptr_p1]     <= i_in_b.dst;
            wr_dst_q[head_ptr_p1]  <= i_in_b.writes_dst;
            is_mem_q[head_ptr_p1]  <= i_in_b.is_mem;
            imm_q[head_ptr_p1]     <= i_in_b.imm;
            illegal_q[head_ptr_p1] <= i_in_b.illegal;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // pointers, occupancy and status
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (occ_next)
            IB_CNT_W'(0): head_valid_d = 2'b00;
            IB_CNT_W'(1): head_valid_d = 2'b10;  // oldest only
            default:      head_valid_d = 2'b11;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head_ptr     <= '0;
            tail_ptr     <= '0;
            occ          <= '0;
            o_head_valid <= 2'b00;
            o_full       <= 1'b0;
        end else if (i_flush) begin
            head_ptr     <= '0;              // this cycle's writes are dropped
            tail_ptr     <= '0;
            occ          <= '0;
            o_head_valid <= 2'b00;
            o_full       <= 1'b0;
        end else begin
            head_ptr     <= head_ptr + IB_PTR_W'(num_wr);
            tail_ptr     <= tail_ptr + IB_PTR_W'(i_issue_num);
            occ          <= occ_next;
            o_head_valid <= head_valid_d;
            o_full       <= (occ_next >= IB_CNT_W'(IB_FULL_LEVEL));
        end
    end

    // two oldest entries, qualified by o_head_valid
    assign o_head_a.valid      = o_head_valid[1];
    assign o_head_a.pc         = pc_q[tail_ptr];
    assign o_head_a.src1       = src1_q[tail_ptr];
    assign o_head_a.src2       = src2_q[tail_ptr];
    assign o_head_a.dst        = dst_q[tail_ptr];
    assign o_head_a.writes_dst = wr_dst_q[tail_ptr];
    assign o_head_a.is_mem     = is_mem_q[tail_ptr];
    assign o_head_a.imm        = imm_q[tail_ptr];
    assign o_head_a.illegal    = illegal_q[tail_ptr];

    assign o_head_b.valid      = o_head_valid[0];
    assign o_head_b.pc         = pc_q[tail_ptr_p1];
    assign o_head_b.src1       = src1_q[tail_ptr_p1];
    assign o_head_b.src2       = src2_q[tail_ptr_p1];
    assign o_head_b.dst        = dst_q[tail_ptr_p1];
    assign o_head_b.writes_dst = wr_dst_q[tail_ptr_p1];
    assign o_head_b.is_mem     = is_mem_q[tail_ptr_p1];
    assign o_head_b.imm        = imm_q[tail_ptr_p1];
    assign o_head_b.illegal    = illegal_q[tail_ptr_p1];

endmodule

`default_nettype wire

// File: logic/issue_pkg.sv
`default_nettype none

package issue_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // issue buffer geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned IB_DEPTH      = 16;
    localparam int unsigned IB_PTR_W      = 4;     // log2 of depth
    localparam int unsigned IB_CNT_W      = 5;     // holds 0..IB_DEPTH
    localparam int unsigned IB_FULL_LEVEL = 10;    // six entries of slack

    ////////////////////////////////////////////////////////////////////////////
    // opcode field, bits 31:26 in every form
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [5:0] OP_ALU_R  = 6'h01;   // rd = rj op rk
    localparam logic [5:0] OP_ALU_I  = 6'h02;   // rd = rj op imm
    localparam logic [5:0] OP_LOAD   = 6'h0a;   // rd = mem[rj + imm]
    localparam logic [5:0] OP_STORE  = 6'h0b;   // mem[rj + imm] = rd
    localparam logic [5:0] OP_BRANCH = 6'h16;   // compare rj with rd

    // one raw word, two decodings
    //   register form : opcode | funct | rk | rj | rd
    //   immediate form: opcode | imm16      | rj | rd
    typedef union packed {
        struct packed {
            logic [5:0]  opcode;
            logic [10:0] funct;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] imm16;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } i;
    } inst_word_u;

endpackage

`default_nettype wire

// File: logic/issue_select.sv
`timescale 1ns/10ps
`default_nettype none

module issue_select (
    slot_if.consumer          i_head_a,
    slot_if.consumer          i_head_b,
    input  wire logic [1:0]   i_head_valid,
    input  wire logic         i_stall,

    output      logic [1:0]   o_issue_num,
    output      logic [1:0]   o_issue_valid,
    output      logic [4:0]   o_raddr_a1,
    output      logic [4:0]   o_raddr_a2,
    output      logic [4:0]   o_raddr_b1,
    output      logic [4:0]   o_raddr_b2,
    output      logic [31:0]  o_pc_a,
    output      logic [31:0]  o_pc_b,
    output      logic         o_illegal_a
);

    logic issue_a;
    logic issue_b;
    logic raw_hazard;
    logic mem_pair;

    ////////////////////////////////////////////////////////////////////////////
    // pair checks, only between the two oldest entries
    ////////////////////////////////////////////////////////////////////////////

    // b reads what a writes, r0 never counts
    assign raw_hazard = i_head_a.writes_dst && (i_head_a.dst != 5'd0) &&
                        ((i_head_b.src1 == i_head_a.dst) ||
                         (i_head_b.src2 == i_head_a.dst));

    assign mem_pair = i_head_a.is_mem & i_head_b.is_mem;  // one memory port

    assign issue_a = i_head_valid[1] & ~i_stall;
    assign issue_b = issue_a & i_head_valid[0] & ~raw_hazard & ~mem_pair;

    assign o_issue_valid = {issue_a, issue_b};
    assign o_issue_num   = {issue_b, issue_a & ~issue_b};   // 0, 1 or 2

    // register file read side
    assign o_raddr_a1 = i_head_a.src1;
    assign o_raddr_a2 = i_head_a.src2;
    assign o_raddr_b1 = i_head_b.src1;
    assign o_raddr_b2 = i_head_b.src2;
    assign o_pc_a     = i_head_a.pc;
    assign o_pc_b     = i_head_b.pc;

    assign o_illegal_a = i_head_valid[1] & i_head_a.illegal;

endmodule

`default_nettype wire

// File: logic/issue_top.sv
`timescale 1ns/10ps
`default_nettype none

module issue_top (
    input  wire logic        clk,
    input  wire logic        rstn,

    // fetch side, must hold while o_full is high
    input  wire logic        i_valid_a,
    input  wire logic        i_valid_b,
    input  wire logic [31:0] i_inst_a,
    input  wire logic [31:0] i_inst_b,
    input  wire logic [31:0] i_pc_a,
    input  wire logic [31:0] i_pc_b,

    input  wire logic        i_flush,    // branch redirect pulse
    input  wire logic        i_stall,    // cache or divider busy

    output      logic [1:0]  o_issue_valid,
    output      logic [4:0]  o_raddr_a1,
    output      logic [4:0]  o_raddr_a2,
    output      logic [4:0]  o_raddr_b1,
    output      logic [4:0]  o_raddr_b2,
    output      logic [31:0] o_pc_a,
    output      logic [31:0] o_pc_b,
    output      logic        o_illegal_a,
    output      logic        o_full
);

    logic [1:0] issue_num;
    logic [1:0] head_valid;

    slot_if dec_a_if ();
    slot_if dec_b_if ();
    slot_if head_a_if ();
    slot_if head_b_if ();

    inst_decoder u_dec_a (
        .i_inst  (i_inst_a),
        .i_pc    (i_pc_a),
        .i_valid (i_valid_a),
        .o_slot  (dec_a_if.producer)
    );

    inst_decoder u_dec_b (
        .i_inst  (i_inst_b),
        .i_pc    (i_pc_b),
        .i_valid (i_valid_b),
        .o_slot  (dec_b_if.producer)
    );

    issue_buffer u_issue_buffer (
        .clk          (clk),
        .rstn         (rstn),
        .i_in_a       (dec_a_if.consumer),
        .i_in_b       (dec_b_if.consumer),
        .i_flush      (i_flush),
        .i_issue_num  (issue_num),
        .o_head_a     (head_a_if.producer),
        .o_head_b     (head_b_if.producer),
        .o_head_valid (head_valid),
        .o_full       (o_full)
    );

    // combinational, same cycle as the buffer head
    issue_select u_issue_select (
        .i_head_a      (head_a_if.consumer),
        .i_head_b      (head_b_if.consumer),
        .i_head_valid  (head_valid),
        .i_stall       (i_stall),
        .o_issue_num   (issue_num),
        .o_issue_valid (o_issue_valid),
        .o_raddr_a1    (o_raddr_a1),
        .o_raddr_a2    (o_raddr_a2),
        .o_raddr_b1    (o_raddr_b1),
        .o_raddr_b2    (o_raddr_b2),
        .o_pc_a        (o_pc_a),
        .o_pc_b        (o_pc_b),
        .o_illegal_a   (o_illegal_a)
    );

endmodule

`default_nettype wire

// File: logic/slot_if.sv
`timescale 1ns/10ps
`default_nettype none

// one decoded instruction slot
interface slot_if;

    logic        valid;
    logic [31:0] pc;
    logic [4:0]  src1;        // first read address
    logic [4:0]  src2;        // second read address, 0 when unused
    logic [4:0]  dst;
    logic        writes_dst;
    logic        is_mem;      // load or store
    logic [31:0] imm;
    logic        illegal;

    modport producer (
        output valid, pc, src1, src2, dst,
        output writes_dst, is_mem, imm, illegal
    );

    modport consumer (
        input  valid, pc, src1, src2, dst,
        input  writes_dst, is_mem, imm, illegal
    );

endinterface

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# compile with Verilator and run the issue testbench
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module issue_tb -f build.f -o issue_sim

./obj_dir/issue_sim 2>&1 | tee sim.log

if grep -qx "TESTBENCH PASSED" sim.log; then
    echo "run.sh: simulation ok"
    exit 0
fi
echo "run.sh: simulation reported failure"
exit 1
